//--- sim/controlUnitStimulus.txt
# wait instr ctrl addrPhase, all hex
# a wait of ff lets the slave model pick 0 to 3 wait states at random
00 0000 00000000 00
03 3abc 00000000 00
00 c423 0804f0d8 00
01 c957 1024f098 00
02 fe10 7804f0d8 00
ff dd41 3824f098 00
00 c0ab 0004f0d8 00
00 4034 0002f040 20
01 4912 0832d040 10
ff 4568 0821b040 10
02 4c9a 00119040 20
03 5277 0002f040 20
00 8105 00003018 01
01 8620 0000b018 06
ff a1e3 0000f118 01
00 a812 0000f118 08
02 9204 00023058 22
ff b412 0002f158 24
00 8f00 00003018 00

//--- list.f
source/cpuIsaPkg.sv
source/ctrlWordPkg.sv
source/controlSequencer.sv
source/aluGroupDecoder.sv
source/loadStoreDecoder.sv
source/jumpDecoder.sv
source/controlSelect.sv
source/controlUnit.sv
sim/controlUnitTb.sv

//--- sim/controlUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnitTb;

	localparam time clkPeriod = 40ns;
	localparam time driveDelay = 2ns;
	localparam int resetCycles = 8;
	localparam int unsigned rngSeed = 32'hfe90_f500;
	localparam ctrlWordPkg::addrPhase_t phaseIdle = '{
		addrBus: ctrlWordPkg::addrPcA,
		pcBase: ctrlWordPkg::basePcA,
		pcOffset: ctrlWordPkg::off2
	};

	logic CLK;
	logic RESET;
	cpuIsaPkg::addr_t pcAddr;
	cpuIsaPkg::wbRsp_t wbRsp;
	cpuIsaPkg::wbReq_t wbReq;
	ctrlWordPkg::ctrlWord_t ctrl;
	ctrlWordPkg::addrPhase_t addrPhase;
	logic fetch;
	logic execute;

	int waitList[$];
	cpuIsaPkg::instrWord_t wordList[$];
	ctrlWordPkg::ctrlWord_t ctrlList[$];
	ctrlWordPkg::addrPhase_t phaseList[$];
	bit stimulusLoaded = 1'b0;

	initial CLK = 1'b0;
	always #(clkPeriod / 2) CLK = ~CLK;

	controlUnit dut_i (
		.CLK(CLK),
		.RESET(RESET),
		.pcAddr(pcAddr),
		.wbRsp(wbRsp),
		.wbReq(wbReq),
		.ctrl(ctrl),
		.addrPhase(addrPhase),
		.fetch(fetch),
		.execute(execute)
	);

	task automatic abortRun();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic nextCycle();
		@(posedge CLK);
		#driveDelay;
	endtask

	function automatic cpuIsaPkg::wbReq_t busRequest(input logic active,
			input cpuIsaPkg::addr_t adr);
		cpuIsaPkg::wbReq_t req;
		req.cyc = active;
		req.stb = active;
		req.adr = adr;
		return req;
	endfunction

	task automatic checkCtrl(input ctrlWordPkg::ctrlWord_t expected);
		if (ctrl !== expected) begin
			$display("[ERROR] ctrl expected %h actual %h at %0t", expected, ctrl, $time);
			abortRun();
		end
	endtask

	task automatic checkAddrPhase(input ctrlWordPkg::addrPhase_t expected);
		if (addrPhase !== expected) begin
			$display("[ERROR] addrPhase expected %h actual %h at %0t", expected, addrPhase,
				$time);
			abortRun();
		end
	endtask

	task automatic checkWbReq(input cpuIsaPkg::wbReq_t expected);
		logic mismatch;
		mismatch = (wbReq.cyc !== expected.cyc) || (wbReq.stb !== expected.stb);
		if (expected.cyc && (wbReq.adr !== expected.adr)) begin
			mismatch = 1'b1; // adr only matters while the cycle is open.
		end
		if (mismatch) begin
			$display("[ERROR] wbReq expected %h actual %h at %0t", expected, wbReq, $time);
			abortRun();
		end
	endtask

	task automatic checkSeqFlags(input logic expFetch, input logic expExecute);
		if (fetch !== expFetch) begin
			$display("[ERROR] fetch expected %h actual %h at %0t", expFetch, fetch, $time);
			abortRun();
		end
		if (execute !== expExecute) begin
			$display("[ERROR] execute expected %h actual %h at %0t", expExecute, execute,
				$time);
			abortRun();
		end
	endtask

	task automatic loadStimulus();
		int fd;
		int got;
		int fields;
		string line;
		int waitVal;
		logic [15:0] wordVal;
		logic [$bits(ctrlWordPkg::ctrlWord_t)-1:0] ctrlVal;
		logic [$bits(ctrlWordPkg::addrPhase_t)-1:0] phaseVal;
		fd = $fopen("sim/controlUnitStimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file sim/controlUnitStimulus.txt");
			abortRun();
		end
		while (!$feof(fd)) begin
			line = "";
			got = $fgets(line, fd);
			if (got > 1 && line[0] != "#") begin
				fields = $sscanf(line, "%h %h %h %h", waitVal, wordVal, ctrlVal, phaseVal);
				if (fields != 4) begin
					$display("malformed stimulus line: %s", line);
					abortRun();
				end
				waitList.push_back(waitVal);
				wordList.push_back(wordVal);
				ctrlList.push_back(ctrlWordPkg::ctrlWord_t'(ctrlVal));
				phaseList.push_back(ctrlWordPkg::addrPhase_t'(phaseVal));
			end
		end
		$fclose(fd);
		if (wordList.size() == 0) begin
			$display("the stimulus file holds no instructions");
			abortRun();
		end
	endtask

	// slave side of one read, entered in the first fetch cycle.
	task automatic serveFetch(input int waitCount, input cpuIsaPkg::instrWord_t word,
			input cpuIsaPkg::addr_t adr, input ctrlWordPkg::addrPhase_t firstPhase);
		int stalls;
		int cycle;
		stalls = (waitCount == 'hff) ? int'($urandom % 4) : waitCount;
		pcAddr = adr;
		for (cycle = 0; cycle <= stalls; cycle++) begin
			if (cycle == stalls) begin
				wbRsp.dat = word;
				wbRsp.ack = 1'b1;
			end
			@(negedge CLK);
			checkSeqFlags(1'b1, 1'b0);
			checkWbReq(busRequest(1'b1, adr));
			checkAddrPhase((cycle == 0) ? firstPhase : phaseIdle); // previous instruction first.
			nextCycle();
		end
		wbRsp.ack = 1'b0;
		wbRsp.dat = '0;
	endtask

	initial begin
		wait (stimulusLoaded);
		repeat (wordList.size() * 10 + 50) @(posedge CLK);
		$display("watchdog expired after %0d clock periods, the run hung",
			wordList.size() * 10 + 50);
		abortRun();
	end

	initial begin
		ctrlWordPkg::addrPhase_t lastPhase;
		cpuIsaPkg::addr_t fetchAddr;
		int n;
		void'($urandom(rngSeed));
		RESET = 1'b1;
		pcAddr = '0;
		wbRsp = '0;
		loadStimulus();
		stimulusLoaded = 1'b1;

		repeat (resetCycles) begin
			@(negedge CLK);
			checkSeqFlags(1'b0, 1'b0);
			checkWbReq(busRequest(1'b0, '0));
			checkAddrPhase(phaseIdle);
		end
		nextCycle();
		RESET = 1'b0;

		@(negedge CLK);
		checkSeqFlags(1'b0, 1'b0); // one idle cycle before the first fetch.
		checkWbReq(busRequest(1'b0, '0));
		checkAddrPhase(phaseIdle);
		nextCycle();

		lastPhase = phaseIdle;
		fetchAddr = 16'h0100;
		for (n = 0; n < wordList.size(); n++) begin
			serveFetch(waitList[n], wordList[n], fetchAddr, lastPhase);
			@(negedge CLK);
			checkSeqFlags(1'b0, 1'b1);
			checkWbReq(busRequest(1'b0, '0));
			checkCtrl(ctrlList[n]);
			checkAddrPhase(phaseIdle);
			nextCycle();
			lastPhase = phaseList[n];
			fetchAddr = fetchAddr + 16'd2;
		end

		@(negedge CLK);
		checkSeqFlags(1'b1, 1'b0); // no ack follows, so the FSM waits in fetch.
		checkAddrPhase(lastPhase);
		nextCycle();
		@(negedge CLK);
		checkAddrPhase(phaseIdle);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire cpuIsaPkg::addr_t     pcAddr,
	input  wire cpuIsaPkg::wbRsp_t    wbRsp,
	output cpuIsaPkg::wbReq_t         wbReq,
	output ctrlWordPkg::ctrlWord_t    ctrl,
	output ctrlWordPkg::addrPhase_t   addrPhase,
	output logic                      fetch,
	output logic                      execute
);

	cpuIsaPkg::instrFields_t instr;
	ctrlWordPkg::groupCtrl_t aluCtrl;
	ctrlWordPkg::groupCtrl_t lsCtrl;
	ctrlWordPkg::groupCtrl_t jmpCtrl;

	controlSequencer sequencer_i (
		.CLK(CLK),
		.RESET(RESET),
		.pcAddr(pcAddr),
		.wbRsp(wbRsp),
		.wbReq(wbReq),
		.instr(instr),
		.fetch(fetch),
		.execute(execute)
	);

	aluGroupDecoder aluDecoder_i (.instr(instr), .groupCtrl(aluCtrl));
	loadStoreDecoder lsDecoder_i (.instr(instr), .groupCtrl(lsCtrl));
	jumpDecoder jmpDecoder_i (.instr(instr), .groupCtrl(jmpCtrl));

	controlSelect select_i (
		.CLK(CLK),
		.RESET(RESET),
		.group(instr.group),
		.fetch(fetch),
		.execute(execute),
		.aluCtrl(aluCtrl),
		.lsCtrl(lsCtrl),
		.jmpCtrl(jmpCtrl),
		.ctrl(ctrl),
		.addrPhase(addrPhase)
	);

endmodule

`default_nettype wire

//--- source/controlSelect.sv
`timescale 1ns/100ps
`default_nettype none

module controlSelect (
	input  wire logic                      CLK,
	input  wire logic                      RESET,
	input  wire cpuIsaPkg::instrGroup_t    group,
	input  wire logic                      fetch,
	input  wire logic                      execute,
	input  wire ctrlWordPkg::groupCtrl_t   aluCtrl,
	input  wire ctrlWordPkg::groupCtrl_t   lsCtrl,
	input  wire ctrlWordPkg::groupCtrl_t   jmpCtrl,
	output ctrlWordPkg::ctrlWord_t         ctrl,
	output ctrlWordPkg::addrPhase_t        addrPhase
);

	ctrlWordPkg::groupCtrl_t sel;

	always_comb begin
		sel = ctrlWordPkg::ctrlDefault; // system group keeps every default.
		case (group)
			cpuIsaPkg::grpLoadStore: begin
				sel = lsCtrl;
				sel.pcBase = ctrlWordPkg::basePcA;
			end
			cpuIsaPkg::grpJump: begin
				sel = jmpCtrl;
				sel.aluOp = ctrlWordPkg::aluMov;
				sel.aluASrc = ctrlWordPkg::srcRegA;
				sel.aluBSrc = ctrlWordPkg::srcRegB;
				sel.byteSel = ctrlWordPkg::byteWord;
				sel.dataBus = ctrlWordPkg::busRegADout;
				sel.wr = 1'b0;
				sel.regA.byteEn = ctrlWordPkg::byteEnBoth;
				sel.regB.byteEn = ctrlWordPkg::byteEnBoth;
				sel.regB.wen = 1'b0;
			end
			cpuIsaPkg::grpAluLogic: begin
				sel = aluCtrl;
				sel.byteSel = ctrlWordPkg::byteWord;
				sel.dataBus = ctrlWordPkg::busAluR;
				sel.regADin = ctrlWordPkg::dinAluR;
				sel.rd = 1'b0;
				sel.wr = 1'b0;
				sel.regA.byteEn = ctrlWordPkg::byteEnBoth;
				sel.regB.byteEn = ctrlWordPkg::byteEnBoth;
				sel.addrBus = ctrlWordPkg::addrPcA; // next fetch comes from PC.
				sel.pcBase = ctrlWordPkg::basePcA;
				sel.pcOffset = ctrlWordPkg::off2;
			end
			default: begin
				sel = ctrlWordPkg::ctrlDefault;
			end
		endcase
	end

	always_comb begin
		ctrl.aluOp = sel.aluOp;
		ctrl.aluASrc = sel.aluASrc;
		ctrl.aluBSrc = sel.aluBSrc;
		ctrl.byteSel = sel.byteSel;
		ctrl.dataBus = sel.dataBus;
		ctrl.rd = sel.rd;
		ctrl.wr = sel.wr;
		ctrl.regA = sel.regA;
		ctrl.regADin = sel.regADin;
		ctrl.regB = sel.regB;
	end

	// address phase belongs to the cycle after execute, fetch puts it back.
	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			addrPhase <= ctrlWordPkg::addrPhaseDefault;
		end else if (fetch) begin
			addrPhase <= ctrlWordPkg::addrPhaseDefault;
		end else if (execute) begin
			addrPhase.addrBus <= sel.addrBus;
			addrPhase.pcBase <= sel.pcBase;
			addrPhase.pcOffset <= sel.pcOffset;
		end
	end

endmodule

`default_nettype wire

//--- source/jumpDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module jumpDecoder (
	input  wire cpuIsaPkg::instrFields_t instr,
	output ctrlWordPkg::groupCtrl_t      groupCtrl
);

	logic isCall;
	logic isIndirect;

	assign isCall = instr.op[cpuIsaPkg::opCallBit];
	assign isIndirect = instr.op[cpuIsaPkg::opIndirectBit];

	always_comb begin
		groupCtrl = ctrlWordPkg::ctrlDefault;
		groupCtrl.regA.addrSel = {1'b0, ctrlWordPkg::regAArgA};
		groupCtrl.regB.addrSel = ctrlWordPkg::regBArgB;

		case (instr.op[1:0])
			2'd1: groupCtrl.pcBase = ctrlWordPkg::baseRegA;
			2'd2: groupCtrl.pcBase = ctrlWordPkg::baseAluR;
			default: groupCtrl.pcBase = ctrlWordPkg::basePcA;
		endcase

		case (instr.mode)
			2'd1: groupCtrl.pcOffset = ctrlWordPkg::offImm;
			2'd2: groupCtrl.pcOffset = ctrlWordPkg::off0;
			default: groupCtrl.pcOffset = ctrlWordPkg::off2;
		endcase

		groupCtrl.regA.en = isCall || (groupCtrl.pcBase == ctrlWordPkg::baseRegA);
		if (isCall) begin
			groupCtrl.regA.wen = 1'b1; // return address is the current PC.
			groupCtrl.regADin = ctrlWordPkg::dinPc;
		end

		if (isIndirect) begin
			groupCtrl.rd = 1'b1;
			groupCtrl.addrBus = ctrlWordPkg::addrRegB;
			groupCtrl.regB.en = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/loadStoreDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module loadStoreDecoder (
	input  wire cpuIsaPkg::instrFields_t instr,
	output ctrlWordPkg::groupCtrl_t      groupCtrl
);

	logic isStore;
	logic isByte;

	assign isStore = instr.op[cpuIsaPkg::opStoreBit];
	assign isByte = instr.op[cpuIsaPkg::opByteBit];

	always_comb begin
		groupCtrl = ctrlWordPkg::ctrlDefault;
		groupCtrl.pcOffset = ctrlWordPkg::off2;

		groupCtrl.regA.en = 1'b1;
		groupCtrl.regA.addrSel = {1'b0, ctrlWordPkg::regAArgA};
		groupCtrl.regB.en = 1'b1; // regB holds the base address.
		groupCtrl.regB.addrSel = ctrlWordPkg::regBArgB;

		if (isStore) begin
			groupCtrl.wr = 1'b1;
			groupCtrl.dataBus = ctrlWordPkg::busRegADout;
		end else begin
			groupCtrl.rd = 1'b1;
			groupCtrl.regA.wen = 1'b1;
			groupCtrl.regADin = ctrlWordPkg::dinData;
		end

		if (isByte) begin
			groupCtrl.byteSel = ctrlWordPkg::byteLow;
			groupCtrl.regA.byteEn = ctrlWordPkg::byteEnLow;
		end else begin
			groupCtrl.byteSel = ctrlWordPkg::byteWord;
			groupCtrl.regA.byteEn = ctrlWordPkg::byteEnBoth;
		end

		if (instr.mode == cpuIsaPkg::modeImm) begin
			groupCtrl.addrBus = ctrlWordPkg::addrAluR; // address is base plus a small offset.
			groupCtrl.aluBSrc = ctrlWordPkg::srcImm4;
			groupCtrl.aluOp = ctrlWordPkg::aluAdd;
		end else begin
			groupCtrl.addrBus = ctrlWordPkg::addrRegB;
		end
	end

endmodule

`default_nettype wire

//--- source/aluGroupDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module aluGroupDecoder (
	input  wire cpuIsaPkg::instrFields_t instr,
	output ctrlWordPkg::groupCtrl_t      groupCtrl
);

	logic immMode;

	assign immMode = (instr.mode == cpuIsaPkg::modeImm);

	always_comb begin
		groupCtrl = ctrlWordPkg::ctrlDefault;
		groupCtrl.aluOp = ctrlWordPkg::aluOp_t'(instr.op); // op field is the ALU operation.
		groupCtrl.aluASrc = ctrlWordPkg::srcRegA;

		groupCtrl.regA.en = 1'b1;
		groupCtrl.regA.wen = 1'b1;
		groupCtrl.regA.addrSel = {1'b0, ctrlWordPkg::regAArgA};

		groupCtrl.regB.addrSel = ctrlWordPkg::regBArgB;
		if (immMode) begin
			groupCtrl.aluBSrc = ctrlWordPkg::srcImm4; // argB is the operand itself.
			groupCtrl.regB.en = 1'b0;
		end else begin
			groupCtrl.aluBSrc = ctrlWordPkg::srcRegB;
			groupCtrl.regB.en = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/controlSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module controlSequencer (
	input  wire logic                 CLK,
	input  wire logic                 RESET,
	input  wire cpuIsaPkg::addr_t     pcAddr,
	input  wire cpuIsaPkg::wbRsp_t    wbRsp,
	output cpuIsaPkg::wbReq_t         wbReq,
	output cpuIsaPkg::instrFields_t   instr,
	output logic                      fetch,
	output logic                      execute
);

	ctrlWordPkg::seqState_t state;
	ctrlWordPkg::seqState_t nextState;
	cpuIsaPkg::instrWord_t instrReg;

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			state <= ctrlWordPkg::seqIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			ctrlWordPkg::seqIdle: begin
				nextState = ctrlWordPkg::seqFetch;
			end
			ctrlWordPkg::seqFetch: begin
				if (wbRsp.ack) begin
					nextState = ctrlWordPkg::seqExecute; // wait states just hold here.
				end
			end
			ctrlWordPkg::seqExecute: begin
				nextState = ctrlWordPkg::seqFetch;
			end
			default: begin
				nextState = ctrlWordPkg::seqIdle;
			end
		endcase
	end

	assign fetch = (state == ctrlWordPkg::seqFetch);
	assign execute = (state == ctrlWordPkg::seqExecute);

	// one read per instruction, the request falls as soon as the FSM leaves fetch.
	assign wbReq.cyc = fetch;
	assign wbReq.stb = fetch;
	assign wbReq.adr = fetch ? pcAddr : '0;

	always_ff @(posedge CLK) begin
		if (fetch && wbRsp.ack) begin
			instrReg <= wbRsp.dat;
		end
	end

	assign instr = cpuIsaPkg::instrFields_t'(instrReg);

endmodule

`default_nettype wire

//--- source/ctrlWordPkg.sv
`default_nettype none

package ctrlWordPkg;

	typedef enum logic [3:0] {
		aluMov, aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNot, aluShl,
		aluShr, aluAsr, aluRol, aluRor, aluAdc, aluSbc, aluCmp, aluNeg
	} aluOp_t;

	typedef enum logic [2:0] {srcRegA = 3'd0, srcPc = 3'd1} aluASrc_t;
	typedef enum logic [2:0] {srcRegB = 3'd0, srcImm4 = 3'd1, srcConst2 = 3'd2} aluBSrc_t;
	typedef enum logic {byteWord = 1'b0, byteLow = 1'b1} byteSel_t;
	typedef enum logic [1:0] {busRegADout = 2'd0, busAluR = 2'd1, busMem = 2'd2} dataBus_t;
	typedef enum logic [1:0] {addrPcA = 2'd0, addrAluR = 2'd1, addrRegB = 2'd2} addrBus_t;
	typedef enum logic [1:0] {basePcA = 2'd0, baseRegA = 2'd1, baseAluR = 2'd2} pcBase_t;
	typedef enum logic [1:0] {off2 = 2'd0, offImm = 2'd1, off0 = 2'd2} pcOffset_t;
	typedef enum logic [1:0] {regAArgA = 2'd0, regAArgB = 2'd1} regASel_t;
	typedef enum logic [2:0] {regBArgB = 3'd0, regBArgA = 3'd1, regBLink = 3'd2} regBSel_t;
	typedef enum logic [1:0] {
		byteEnNone = 2'd0,
		byteEnLow  = 2'd1,
		byteEnHigh = 2'd2,
		byteEnBoth = 2'd3
	} byteEn_t;
	typedef enum logic [1:0] {dinData = 2'd0, dinAluR = 2'd1, dinPc = 2'd2} regADin_t;

	typedef struct packed {
		logic       en;
		logic       wen;
		byteEn_t    byteEn;
		logic [2:0] addrSel; // regA only uses the low two bits.
	} regPortCtrl_t;

	typedef struct packed {
		aluOp_t       aluOp;
		aluASrc_t     aluASrc;
		aluBSrc_t     aluBSrc;
		byteSel_t     byteSel;
		dataBus_t     dataBus;
		pcBase_t      pcBase;
		pcOffset_t    pcOffset;
		addrBus_t     addrBus;
		logic         rd;
		logic         wr;
		regPortCtrl_t regA;
		regADin_t     regADin;
		regPortCtrl_t regB;
	} groupCtrl_t;

	typedef struct packed {
		aluOp_t       aluOp;
		aluASrc_t     aluASrc;
		aluBSrc_t     aluBSrc;
		byteSel_t     byteSel;
		dataBus_t     dataBus;
		logic         rd;
		logic         wr;
		regPortCtrl_t regA;
		regADin_t     regADin;
		regPortCtrl_t regB;
	} ctrlWord_t;

	typedef struct packed {
		addrBus_t  addrBus;
		pcBase_t   pcBase;
		pcOffset_t pcOffset;
	} addrPhase_t;

	typedef enum logic [1:0] {seqIdle = 2'd0, seqFetch = 2'd1, seqExecute = 2'd2} seqState_t;

	// every default encoding is zero, so an idle group is all zeros.
	localparam groupCtrl_t ctrlDefault = '0;
	localparam addrPhase_t addrPhaseDefault = '{addrBus: addrPcA, pcBase: basePcA, pcOffset: off2};

endpackage

`default_nettype wire

//--- source/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	typedef logic [15:0] instrWord_t;
	typedef logic [15:0] addr_t;
	typedef logic [3:0] opcode_t;
	typedef logic [1:0] mode_t;
	typedef logic [3:0] regIdx_t;

	typedef enum logic [1:0] {
		grpSystem    = 2'd0,
		grpLoadStore = 2'd1,
		grpJump      = 2'd2,
		grpAluLogic  = 2'd3
	} instrGroup_t;

	localparam int unsigned opStoreBit = 0; // load/store: set for a store.
	localparam int unsigned opByteBit = 1; // load/store: set for a byte access.
	localparam int unsigned opIndirectBit = 2; // jump: target is read from memory.
	localparam int unsigned opCallBit = 3; // jump: return address goes to regA.
	localparam mode_t modeImm = 2'd1; // argB is a 4-bit immediate.

	typedef struct packed {
		instrGroup_t group;
		opcode_t     op;
		mode_t       mode;
		regIdx_t     argA;
		regIdx_t     argB;
	} instrFields_t;

	// read-only Wishbone classic master signals.
	typedef struct packed {
		logic  cyc;
		logic  stb;
		addr_t adr;
	} wbReq_t;

	typedef struct packed {
		instrWord_t dat;
		logic       ack;
	} wbRsp_t;

endpackage

`default_nettype wire
